// File: rtl/alut_addr_checker.sv
/*
 * address checker of the lookup table
 *  - packet acceptance and latch
 *  - source learning and destination lookup
 *  - age check request on a matching entry
 */
module alut_addr_checker
(
   input  logic                          pclk7,
   input  logic                          n_p_reset7,
   input  logic                          pkt_valid,
   input  logic [alut_pkg::mac_w-1:0]    pkt_src_mac,
   input  logic [alut_pkg::port_w-1:0]   pkt_src_port,
   input  logic [alut_pkg::mac_w-1:0]    pkt_dst_mac,
   output logic                          pkt_ready,
   output logic                          lookup_done,
   output logic                          fwd_hit,
   output logic [alut_pkg::port_w-1:0]   fwd_port,
   alut_age_if.requester                 age,
   alut_mem_if.client                    mem
);
   import alut_pkg::*;

   logic [1:0]        state;
   logic              accept;
   logic              dst_match;      // valid entry holding the destination
   logic [mac_w-1:0]  src_mac_q;
   logic [port_w-1:0] src_port_q;
   logic [mac_w-1:0]  dst_mac_q;
   logic [port_w-1:0] entry_port_q;   // stored port of the destination

   assign pkt_ready            = !age.age_check_active && (state == st_ac_idle);
   assign accept               = pkt_valid && pkt_ready;
   assign age.add_check_active = accept || (state != st_ac_idle);

   // ----------------------------------------------------------------------
   // table port, index is the low mac byte
   // ----------------------------------------------------------------------
   assign mem.addr  = (state == st_ac_write) ? src_mac_q[alut_addr_w-1:0]
                                             : dst_mac_q[alut_addr_w-1:0];
   assign mem.write = (state == st_ac_write);
   assign mem.wdata = {1'b1, age.curr_time, src_port_q, src_mac_q};

   assign dst_match     = mem.rdata[valid_bit] && (mem.rdata[mac_w-1:0] == dst_mac_q);
   assign age.check_age = (state == st_ac_read) && dst_match;

   // packet and entry payload
   always_ff @(posedge pclk7)
   begin
      if (accept)
      begin
         src_mac_q  <= pkt_src_mac;
         src_port_q <= pkt_src_port;
         dst_mac_q  <= pkt_dst_mac;
      end
      if (state == st_ac_read)
      begin
         age.last_accessed <= mem.rdata[time_lsb +: time_w];
         entry_port_q      <= mem.rdata[port_lsb +: port_w];
      end
   end

   // ----------------------------------------------------------------------
   // lookup FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         state       <= st_ac_idle;
         lookup_done <= 1'b0;
         fwd_hit     <= 1'b0;
         fwd_port    <= '0;
      end
      else
      begin
         lookup_done <= 1'b0;
         case (state)
            st_ac_idle:
               if (accept)
                  state <= st_ac_write;
            st_ac_write:
               state <= st_ac_read;
            st_ac_read:
               if (dst_match)
                  state <= st_ac_wait;            // age result in two cycles
               else
               begin
                  state       <= st_ac_idle;      // unknown destination
                  lookup_done <= 1'b1;
                  fwd_hit     <= 1'b0;
                  fwd_port    <= '0;
               end
            st_ac_wait:
               if (age.age_confirmed)
               begin
                  state       <= st_ac_idle;
                  lookup_done <= 1'b1;
                  fwd_hit     <= age.age_ok;
                  fwd_port    <= age.age_ok ? entry_port_q : '0;
               end
            default:
               state <= st_ac_idle;
         endcase
      end
   end

endmodule

// File: rtl/alut_age_checker.sv
/*
 * age checker of the lookup table
 *  - divided current-time counter
 *  - age check answers for the address checker
 *  - aged sweep and invalidate-all sweep over the table
 *  - capture of the last invalidated entry
 */
module alut_age_checker
(
   input  logic        pclk7,
   input  logic        n_p_reset7,
   alut_cfg_if.chkr    cfg,
   alut_age_if.chkr    age,
   alut_mem_if.client  mem
);
   import alut_pkg::*;

   logic [2:0]             state;        // FSM state
   logic [2:0]             nxt_state;
   logic [7:0]             div_cnt;      // clock divider count
   logic [time_w-1:0]      curr_time;
   logic [alut_addr_w-1:0] addr_q;       // sweep address, rests at max_addr
   logic                   cmd_accept;
   logic                   entry_valid;  // valid bit of the swept entry
   logic [time_w-1:0]      stamp;
   logic [time_w-1:0]      elapsed;
   logic                   in_date;

   // ----------------------------------------------------------------------
   // current time
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt >= cfg.div_clk)   // one tick every div_clk+1 cycles
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 1'b1;
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

   assign cfg.curr_time = curr_time;
   assign age.curr_time = curr_time;

   // ----------------------------------------------------------------------
   // state machine
   // ----------------------------------------------------------------------
   // commands only start from idle with no packet in flight
   assign cmd_accept  = (state == st_idle) && cfg.command_valid && !age.add_check_active &&
                        (cfg.command == cmd_inval_aged || cfg.command == cmd_inval_all);
   assign entry_valid = mem.rdata[valid_bit];

   always_comb
   begin
      nxt_state = state;
      case (state)
         st_idle:
            if (cmd_accept && cfg.command == cmd_inval_aged)
               nxt_state = st_inval_aged_rd;
            else if (cmd_accept)
               nxt_state = st_inval_all;
            else if (age.check_age)
               nxt_state = st_age_chk;
         st_inval_aged_rd:
            nxt_state = st_age_chk;          // step onto next entry
         st_inval_aged_wr:
            nxt_state = (addr_q == max_addr) ? st_idle : st_inval_aged_rd;
         st_inval_all:
            if (addr_q == max_addr)
               nxt_state = st_idle;
         st_age_chk:
            if (age.age_confirmed)
            begin
               if (age.add_check_active)     // request from address checker
                  nxt_state = st_idle;
               else if (entry_valid && !age.age_ok)
                  nxt_state = st_inval_aged_wr;
               else if (addr_q == max_addr)  // whole table visited
                  nxt_state = st_idle;
               else
                  nxt_state = st_inval_aged_rd;
            end
         default:
            nxt_state = st_idle;
      endcase
   end

   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
         state <= st_idle;
      else
         state <= nxt_state;
   end

   assign age.age_check_active = (state != st_idle);
   assign cfg.age_check_active = (state != st_idle);

   // ----------------------------------------------------------------------
   // table access, zero words only
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
         addr_q <= max_addr;
      else if ((state == st_inval_aged_rd) ||
               (cmd_accept && cfg.command == cmd_inval_all) ||
               (state == st_inval_all && addr_q != max_addr))
         addr_q <= addr_q + 1'b1;           // 255 wraps to entry 0
   end

   assign mem.addr  = addr_q;
   assign mem.write = (state == st_inval_aged_wr) || (state == st_inval_all);
   assign mem.wdata = '0;

   // age result, elapsed time wraps modulo 2^32
   assign stamp   = age.add_check_active ? age.last_accessed : mem.rdata[time_lsb +: time_w];
   assign elapsed = curr_time - stamp;
   assign in_date = cfg.best_bfr_age > elapsed;

   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         age.age_confirmed <= 1'b0;
         age.age_ok        <= 1'b0;
         cfg.inval_in_prog <= 1'b0;
         cfg.lst_inv_addr  <= '0;
         cfg.lst_inv_port  <= '0;
      end
      else
      begin
         // single pulse per check
         age.age_confirmed <= (state == st_age_chk) && !age.age_confirmed;
         if (state == st_age_chk && !age.age_confirmed)
            age.age_ok <= in_date;
         if (cmd_accept)
            cfg.inval_in_prog <= 1'b1;
         else if (nxt_state == st_idle)
            cfg.inval_in_prog <= 1'b0;
         if (state == st_inval_aged_wr)     // entry being cleared
         begin
            cfg.lst_inv_addr <= mem.rdata[mac_w-1:0];
            cfg.lst_inv_port <= mem.rdata[port_lsb +: port_w];
         end
      end
   end

endmodule

// File: rtl/alut_ifs.sv
/*
 * links inside the lookup table
 *  - alut_mem_if   table port of one client
 *  - alut_age_if   age check between address and age checker
 *  - alut_cfg_if   configuration and status of the age checker
 */
interface alut_mem_if;
   import alut_pkg::*;

   logic [alut_addr_w-1:0] addr;
   logic                   write;     // write at the clock edge
   logic [entry_w-1:0]     wdata;
   logic [entry_w-1:0]     rdata;     // combinational from addr

   modport client (output addr, write, wdata, input rdata);
   modport mem    (input addr, write, wdata, output rdata);
endinterface

interface alut_age_if;
   import alut_pkg::*;

   logic              check_age;         // one-cycle request
   logic [time_w-1:0] last_accessed;     // stamp of the entry under check
   logic              add_check_active;  // packet in flight
   logic              age_confirmed;     // two cycles after check_age
   logic              age_ok;            // valid with age_confirmed
   logic [time_w-1:0] curr_time;
   logic              age_check_active;  // age checker busy

   modport requester (output check_age, last_accessed, add_check_active,
                      input age_confirmed, age_ok, curr_time, age_check_active);
   modport chkr      (input check_age, last_accessed, add_check_active,
                      output age_confirmed, age_ok, curr_time, age_check_active);
   modport monitor   (input age_check_active, add_check_active);
endinterface

interface alut_cfg_if;
   import alut_pkg::*;

   logic [1:0]        command;
   logic              command_valid;     // pulse on a command write
   logic [7:0]        div_clk;
   logic [time_w-1:0] best_bfr_age;
   logic              age_check_active;
   logic              inval_in_prog;
   logic [mac_w-1:0]  lst_inv_addr;
   logic [port_w-1:0] lst_inv_port;
   logic [time_w-1:0] curr_time;

   modport regs (output command, command_valid, div_clk, best_bfr_age,
                 input age_check_active, inval_in_prog, lst_inv_addr, lst_inv_port,
                 curr_time);
   modport chkr (input command, command_valid, div_clk, best_bfr_age,
                 output age_check_active, inval_in_prog, lst_inv_addr, lst_inv_port,
                 curr_time);
endinterface

// File: rtl/alut_mem.sv
/*
 * lookup table storage
 *  - 256 entry array, combinational read, clocked write
 *  - valid vector cleared at reset
 *  - arbitration between address and age checker
 */
module alut_mem
(
   input  logic         pclk7,
   input  logic         n_p_reset7,
   alut_mem_if.mem      addr_mem,
   alut_mem_if.mem      age_mem,
   alut_age_if.monitor  age
);
   import alut_pkg::*;

   logic [entry_w-2:0]     table_q [0:max_addr];  // time, port and mac fields
   logic [max_addr:0]      valid_q;               // one valid bit per entry
   logic                   sel_age;
   logic [alut_addr_w-1:0] addr;
   logic                   write;
   logic [entry_w-1:0]     wdata;
   logic [entry_w-1:0]     rdata;

   // age checker owns the table only with no packet in flight
   assign sel_age = age.age_check_active && !age.add_check_active;
   assign addr    = sel_age ? age_mem.addr  : addr_mem.addr;
   assign write   = sel_age ? age_mem.write : addr_mem.write;
   assign wdata   = sel_age ? age_mem.wdata : addr_mem.wdata;

   assign rdata          = {valid_q[addr], table_q[addr]};
   assign addr_mem.rdata = rdata;
   assign age_mem.rdata  = rdata;

   always_ff @(posedge pclk7)
   begin
      if (write)
         table_q[addr] <= wdata[entry_w-2:0];
   end

   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
         valid_q <= '0;
      else if (write)
         valid_q[addr] <= wdata[valid_bit];
   end

endmodule

// File: rtl/alut_pkg.sv
/*
 * shared definitions for the address lookup table
 *  - table word widths and field positions
 *  - command codes and register offsets
 *  - state codes of the age checker and the address checker
 */
package alut_pkg;

   // table word layout: valid | time stamp | port | mac
   localparam int mac_w       = 48;
   localparam int port_w      = 2;
   localparam int time_w      = 32;
   localparam int alut_addr_w = 8;
   localparam int entry_w     = 83;
   localparam logic [alut_addr_w-1:0] max_addr = '1;   // last table index
   localparam int valid_bit   = 82;
   localparam int time_lsb    = 50;                    // time field 81..50
   localparam int port_lsb    = 48;                    // port field 49..48

   // commands written to reg_command
   localparam logic [1:0] cmd_inval_aged = 2'b10;      // clear stale entries
   localparam logic [1:0] cmd_inval_all  = 2'b11;      // clear every entry

   // register offsets
   localparam logic [3:0] reg_command    = 4'd0;
   localparam logic [3:0] reg_div_clk    = 4'd1;
   localparam logic [3:0] reg_best_bfr   = 4'd2;
   localparam logic [3:0] reg_status     = 4'd3;
   localparam logic [3:0] reg_lst_inv_lo = 4'd4;
   localparam logic [3:0] reg_lst_inv_hi = 4'd5;
   localparam logic [3:0] reg_curr_time  = 4'd6;

   // age checker states
   localparam logic [2:0] st_idle          = 3'd0;
   localparam logic [2:0] st_inval_aged_rd = 3'd1;
   localparam logic [2:0] st_inval_aged_wr = 3'd2;
   localparam logic [2:0] st_inval_all     = 3'd3;
   localparam logic [2:0] st_age_chk       = 3'd4;

   // address checker states
   localparam logic [1:0] st_ac_idle  = 2'd0;
   localparam logic [1:0] st_ac_write = 2'd1;          // learn source
   localparam logic [1:0] st_ac_read  = 2'd2;          // read destination
   localparam logic [1:0] st_ac_wait  = 2'd3;          // wait for age result

endpackage

// File: rtl/alut_regs.sv
/*
 * register block of the lookup table
 *  - command strobe, clock divider, best-before age
 *  - status, last invalidated entry and current time read back
 */
module alut_regs
(
   input  logic        pclk7,
   input  logic        n_p_reset7,
   input  logic        reg_sel,
   input  logic        reg_wr,
   input  logic [3:0]  reg_addr,
   input  logic [31:0] reg_wdata,
   output logic [31:0] reg_rdata,
   alut_cfg_if.regs    cfg
);
   import alut_pkg::*;

   logic wr_en;   // register write strobe

   assign wr_en = reg_sel && reg_wr;

   // ----------------------------------------------------------------------
   // writes
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         cfg.command_valid <= 1'b0;
         cfg.div_clk       <= '0;
         cfg.best_bfr_age  <= '1;              // never stale by default
      end
      else
      begin
         cfg.command_valid <= wr_en && (reg_addr == reg_command);
         if (wr_en && reg_addr == reg_div_clk)
            cfg.div_clk <= reg_wdata[7:0];
         if (wr_en && reg_addr == reg_best_bfr)
            cfg.best_bfr_age <= reg_wdata;
      end
   end

   // command word, qualified by command_valid
   always_ff @(posedge pclk7)
   begin
      if (wr_en && reg_addr == reg_command)
         cfg.command <= reg_wdata[1:0];
   end

   // ----------------------------------------------------------------------
   // read back
   // ----------------------------------------------------------------------
   always_comb
   begin
      case (reg_addr)
         reg_div_clk:    reg_rdata = {24'd0, cfg.div_clk};
         reg_best_bfr:   reg_rdata = cfg.best_bfr_age;
         reg_status:     reg_rdata = {30'd0, cfg.inval_in_prog, cfg.age_check_active};
         reg_lst_inv_lo: reg_rdata = cfg.lst_inv_addr[31:0];
         reg_lst_inv_hi: reg_rdata = {14'd0, cfg.lst_inv_port, cfg.lst_inv_addr[47:32]};
         reg_curr_time:  reg_rdata = cfg.curr_time;
         default:        reg_rdata = '0;      // command is write only
      endcase
   end

endmodule

// File: rtl/alut_top.sv
/*
 * top level of the address lookup table
 *  - register block, age checker, address checker and table
 */
module alut_top
(
   input  logic                          pclk7,
   input  logic                          n_p_reset7,
   // packet side
   input  logic                          pkt_valid,
   input  logic [alut_pkg::mac_w-1:0]    pkt_src_mac,
   input  logic [alut_pkg::port_w-1:0]   pkt_src_port,
   input  logic [alut_pkg::mac_w-1:0]    pkt_dst_mac,
   output logic                          pkt_ready,
   output logic                          lookup_done,
   output logic                          fwd_hit,
   output logic [alut_pkg::port_w-1:0]   fwd_port,
   // register side
   input  logic                          reg_sel,
   input  logic                          reg_wr,
   input  logic [3:0]                    reg_addr,
   input  logic [31:0]                   reg_wdata,
   output logic [31:0]                   reg_rdata
);

   alut_mem_if addr_mem ();   // address checker table port
   alut_mem_if age_mem ();    // age checker table port
   alut_age_if age_link ();
   alut_cfg_if cfg_link ();

   alut_regs regs_inst (
      .pclk7, .n_p_reset7, .reg_sel, .reg_wr, .reg_addr, .reg_wdata, .reg_rdata,
      .cfg (cfg_link)
   );

   alut_age_checker age_checker_inst (
      .pclk7, .n_p_reset7, .cfg (cfg_link), .age (age_link), .mem (age_mem)
   );

   alut_addr_checker addr_checker_inst (
      .pclk7, .n_p_reset7, .pkt_valid, .pkt_src_mac, .pkt_src_port, .pkt_dst_mac,
      .pkt_ready, .lookup_done, .fwd_hit, .fwd_port,
      .age (age_link), .mem (addr_mem)
   );

   alut_mem mem_inst (
      .pclk7, .n_p_reset7, .addr_mem (addr_mem), .age_mem (age_mem), .age (age_link)
   );

endmodule

// File: run.sh
#!/bin/sh
# build the ALUT testbench with Verilator, run it, then search the log for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module alut_tb -f tb.f -o alut_sim &&
   ./obj_dir/alut_sim > sim.log 2>&1 ||
   echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && exit 0 || exit 1

// File: tb.f
rtl/alut_pkg.sv
rtl/alut_ifs.sv
rtl/alut_age_checker.sv
rtl/alut_addr_checker.sv
rtl/alut_mem.sv
rtl/alut_regs.sv
rtl/alut_top.sv
verification/alut_tb.sv

// File: verification/alut_tb.sv
/*
 * directed testbench for the address lookup table
 *  - clock, reset, LCG for MAC addresses and watchdog
 *  - register and packet driver tasks, value check
 *  - tests for time, learning, lookup, aging and both sweeps
 */
module alut_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import alut_pkg::*;

   localparam int clk_period   = 8;
   localparam int max_wait     = 2000;               // cycles allowed for one wait
   localparam int sweep_cycles = 4 * 256 + 256;      // worst aged sweep plus clear all
   localparam int test_cycles  = 3000;               // packets, register access, gaps
   localparam int watchdog_ns  = 2 * (sweep_cycles + test_cycles) * clk_period;

   logic              pclk7;
   logic              n_p_reset7;
   logic              pkt_valid;
   logic [mac_w-1:0]  pkt_src_mac;
   logic [port_w-1:0] pkt_src_port;
   logic [mac_w-1:0]  pkt_dst_mac;
   logic              pkt_ready;
   logic              lookup_done;
   logic              fwd_hit;
   logic [port_w-1:0] fwd_port;
   logic              reg_sel;
   logic              reg_wr;
   logic [3:0]        reg_addr;
   logic [31:0]       reg_wdata;
   logic [31:0]       reg_rdata;

   logic [31:0]       lcg_state;                     // random source for mac bytes
   logic [mac_w-1:0]  mac_a;
   logic [mac_w-1:0]  mac_x;                         // old entry of the aged sweep
   logic [mac_w-1:0]  mac_y;                         // fresh entry of the aged sweep
   logic [mac_w-1:0]  mac_e;

   alut_top alut_top_inst (
      .pclk7, .n_p_reset7, .pkt_valid, .pkt_src_mac, .pkt_src_port, .pkt_dst_mac,
      .pkt_ready, .lookup_done, .fwd_hit, .fwd_port,
      .reg_sel, .reg_wr, .reg_addr, .reg_wdata, .reg_rdata
   );

   always #(clk_period / 2) pclk7 = ~pclk7;

   // ----------------------------------------------------------------------
   // reporting and random macs
   // ----------------------------------------------------------------------
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // random upper bytes, table index forced in the low byte
   function automatic logic [mac_w-1:0] new_mac(input logic [7:0] idx);
      logic [31:0] r1;
      logic [31:0] r2;
      r1 = lcg_next();
      r2 = lcg_next();
      return {r1[15:0], r2[31:8], idx};
   endfunction

   // ----------------------------------------------------------------------
   // drivers
   // ----------------------------------------------------------------------
   task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
      @(posedge pclk7);
      reg_sel   <= 1'b1;
      reg_wr    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge pclk7);                              // taken at this edge
      reg_sel <= 1'b0;
      reg_wr  <= 1'b0;
   endtask

   task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
      @(posedge pclk7);
      reg_addr <= addr;
      @(negedge pclk7);
      data = reg_rdata;                              // read mux settled mid cycle
   endtask

   // poll status until both busy bits drop
   task automatic wait_idle();
      logic [31:0] status;
      int          n;
      n = 0;
      reg_read(reg_status, status);
      while (status != 32'd0)
      begin
         n++;
         if (n > max_wait)
            stop_on_error("sweep did not finish, status stayed busy");
         else
            reg_read(reg_status, status);
      end
   endtask

   // offer one packet, wait for its lookup and check the result
   task automatic lookup(input logic [mac_w-1:0] src, input logic [port_w-1:0] port,
                         input logic [mac_w-1:0] dst, input logic exp_hit,
                         input logic [port_w-1:0] exp_port);
      int n;
      n = 0;
      @(posedge pclk7);
      pkt_valid    <= 1'b1;
      pkt_src_mac  <= src;
      pkt_src_port <= port;
      pkt_dst_mac  <= dst;
      @(negedge pclk7);
      while (!pkt_ready)                             // held until the FSM can take it
      begin
         n++;
         if (n > max_wait)
            stop_on_error("packet was never accepted, pkt_ready stayed low");
         else
            @(negedge pclk7);
      end
      @(posedge pclk7);                              // accepted here
      pkt_valid <= 1'b0;
      n = 0;
      @(negedge pclk7);
      while (!lookup_done)
      begin
         n++;
         if (n > max_wait)
            stop_on_error("lookup_done never pulsed after an accepted packet");
         else
            @(negedge pclk7);
      end
      check("fwd_hit", 64'(fwd_hit), 64'(exp_hit));
      check("fwd_port", 64'(fwd_port), 64'(exp_port));
   endtask

   // ----------------------------------------------------------------------
   // directed tests
   // ----------------------------------------------------------------------
   task automatic test_time_counter();
      logic [31:0] t0;
      logic [31:0] t1;
      logic [31:0] diff;
      reg_read(reg_status, t0);
      check("status after reset", 64'(t0), 64'd0);
      reg_write(reg_div_clk, 32'd3);                 // one tick per 4 cycles
      reg_read(reg_curr_time, t0);
      repeat (79) @(posedge pclk7);                  // samples land 80 cycles apart
      reg_read(reg_curr_time, t1);
      diff = t1 - t0;
      check("curr_time step", (diff >= 32'd19 && diff <= 32'd21) ? 64'd20 : 64'(diff),
            64'd20);
      reg_write(reg_div_clk, 32'd0);                 // one tick per cycle from here on
   endtask

   task automatic test_learn_hit();
      logic [mac_w-1:0] mac_b;
      mac_a = new_mac(8'h11);
      mac_b = new_mac(8'h12);
      lookup(mac_a, 2'd2, mac_b, 1'b0, 2'd0);        // b not learned yet
      lookup(mac_b, 2'd1, mac_a, 1'b1, 2'd2);
   endtask

   task automatic test_unknown_dst();
      lookup(new_mac(8'h40), 2'd0, new_mac(8'h33), 1'b0, 2'd0);   // empty index
      lookup(new_mac(8'h41), 2'd0, new_mac(8'h11), 1'b0, 2'd0);   // a's index, other mac
   endtask

   task automatic test_age_lookup();
      logic [mac_w-1:0] mac_c;
      reg_write(reg_best_bfr, 32'd5);
      mac_c = new_mac(8'h50);
      lookup(mac_c, 2'd3, new_mac(8'h77), 1'b0, 2'd0);
      repeat (12) @(posedge pclk7);                  // stamp now older than 5 ticks
      lookup(new_mac(8'h51), 2'd0, mac_c, 1'b0, 2'd0);
      reg_write(reg_best_bfr, 32'hffff_ffff);
   endtask

   task automatic test_aged_sweep();
      logic [31:0] val;
      mac_x = new_mac(8'hf0);                        // visited near the end of the sweep
      mac_y = new_mac(8'h08);                        // visited early
      lookup(mac_x, 2'd1, new_mac(8'h77), 1'b0, 2'd0);
      repeat (100) @(posedge pclk7);
      lookup(mac_y, 2'd2, new_mac(8'h77), 1'b0, 2'd0);
      // y is about 40 ticks old at its visit, x several hundred
      reg_write(reg_best_bfr, 32'd300);
      reg_write(reg_command, 32'(cmd_inval_aged));
      reg_read(reg_status, val);
      check("status during aged sweep", 64'(val), 64'd3);
      check("pkt_ready during aged sweep", 64'(pkt_ready), 64'd0);
      wait_idle();
      reg_read(reg_lst_inv_lo, val);
      check("lst_inv_lo", 64'(val), 64'(mac_x[31:0]));
      reg_read(reg_lst_inv_hi, val);
      check("lst_inv_hi", 64'(val), 64'({14'd0, 2'd1, mac_x[47:32]}));
      reg_write(reg_best_bfr, 32'hffff_ffff);
      mac_e = new_mac(8'h90);
      lookup(mac_e, 2'd0, mac_x, 1'b0, 2'd0);        // cleared by the sweep
      lookup(new_mac(8'h91), 2'd3, mac_y, 1'b1, 2'd2);
   endtask

   task automatic test_inval_all();
      logic [31:0] val;
      reg_write(reg_command, 32'(cmd_inval_all));
      reg_read(reg_status, val);
      check("status during clear all", 64'(val), 64'd3);
      wait_idle();
      lookup(new_mac(8'hb0), 2'd0, mac_y, 1'b0, 2'd0);
      lookup(new_mac(8'hb1), 2'd0, mac_e, 1'b0, 2'd0);
      lookup(new_mac(8'hb2), 2'd0, mac_a, 1'b0, 2'd0);
   endtask

   // ----------------------------------------------------------------------
   // main sequence and watchdog
   // ----------------------------------------------------------------------
   initial
   begin
      pclk7        = 1'b0;
      n_p_reset7   = 1'b0;
      pkt_valid    = 1'b0;
      pkt_src_mac  = '0;
      pkt_src_port = '0;
      pkt_dst_mac  = '0;
      reg_sel      = 1'b0;
      reg_wr       = 1'b0;
      reg_addr     = '0;
      reg_wdata    = '0;
      lcg_state    = 32'd26338;
      repeat (5) @(posedge pclk7);
      n_p_reset7 <= 1'b1;
      test_time_counter();
      test_learn_hit();
      test_unknown_dst();
      test_age_lookup();
      test_aged_sweep();
      test_inval_all();
      $display("Testbench passed");
      $finish;
   end

   initial
   begin
      #(watchdog_ns);
      stop_on_error("watchdog expired before the tests finished");
   end

endmodule
